// File: bench/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam rv_pkg::word_t START_PC = 32'h0000_0800;
    localparam logic [6:0] OP_IMM   = 7'h13;
    localparam logic [6:0] OP_LUI   = 7'h37;
    localparam logic [6:0] OP_AUIPC = 7'h17;
    localparam logic [6:0] OP_JALR  = 7'h67;
    localparam logic [6:0] OP_LOAD  = 7'h03;

    logic             clk;
    logic             rst;
    logic             stall_en;
    logic             imem_req_valid;
    rv_pkg::mem_req_t imem_req;
    logic             imem_req_ready;
    logic             imem_resp_valid;
    rv_pkg::word_t    imem_resp_rdata;
    logic             dmem_req_valid;
    rv_pkg::mem_req_t dmem_req;
    logic             dmem_req_ready;
    logic             dmem_resp_valid;
    rv_pkg::word_t    dmem_resp_rdata;
    logic             retire_valid;
    rv_pkg::retire_t  retire;

    rv_pkg::retire_t  expq[$];
    rv_pkg::word_t    pc_build;
    int               fails = 0;
    int               cycles = 0;
    int               cycle_limit = 200;

    rv_core dut_i (.*);
    tb_mem  mem_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run exceeded the cycle limit before the programs finished");
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // Fetches are read-only full words.
    always @(negedge clk) begin
        if (imem_req_valid) begin
            check("imem_req.we", 0, 32'(imem_req.we));
            check("imem_req.strb", 32'hf, 32'(imem_req.strb));
        end
    end

    function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [2:0] f3, int rd,
                                             int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic rv_pkg::word_t i_type(logic [6:0] opc, logic [2:0] f3, int rd,
                                             int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t s_type(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
    endfunction

    function automatic rv_pkg::word_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic rv_pkg::word_t u_type(logic [6:0] opc, int rd, logic [19:0] imm);
        return {imm, rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // Background data that differs in every word.
    function automatic rv_pkg::word_t fill_word(rv_pkg::word_t addr);
        return addr ^ (addr << 16) ^ 32'h5a5a_0000;
    endfunction

    function automatic rv_pkg::word_t word_at(rv_pkg::word_t addr);
        return mem_i.mem[addr[11:2]];
    endfunction

    task automatic check(string name, rv_pkg::word_t exp, rv_pkg::word_t act);
        if (exp !== act) begin
            fails++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic place(rv_pkg::word_t addr, rv_pkg::word_t data);
        mem_i.mem[addr[11:2]] = data;
    endtask

    task automatic expect_retire(rv_pkg::word_t pc, int rd, rv_pkg::word_t val);
        rv_pkg::retire_t r;
        r.pc    = pc;
        r.rd    = rd[4:0];
        r.wdata = val;
        r.we    = (rd != 0);
        expq.push_back(r);
    endtask

    task automatic emit(rv_pkg::word_t ins, int rd, rv_pkg::word_t val);
        place(pc_build, ins);
        expect_retire(pc_build, rd, val);
        pc_build += 4;
    endtask

    // Never executed if the preceding branch is right.
    task automatic skip_slot();
        place(pc_build, i_type(OP_IMM, 3'b000, 31, 0, -1));
        pc_build += 4;
    endtask

    task automatic branch(logic [2:0] f3, int rs1, int rs2, logic taken);
        emit(b_type(f3, rs1, rs2, 8), 0, 0);
        if (taken) begin
            skip_slot();
        end
    endtask

    task automatic halt();
        emit(j_type(0, 0), 0, 0);
    endtask

    // Holds rst for 2 cycles and loads memory while the core is in reset.
    task automatic start_reset(logic stall);
        int i;
        @(posedge clk);
        rst      <= 1'b1;
        stall_en <= stall;
        @(posedge clk);
        @(negedge clk);
        check("retire_valid", 0, 32'(retire_valid));
        check("imem_req_valid", 0, 32'(imem_req_valid));
        check("dmem_req_valid", 0, 32'(dmem_req_valid));
        for (i = 0; i < 1024; i++) begin
            mem_i.mem[i] = fill_word(i * 4);
        end
        pc_build = START_PC;
    endtask

    task automatic run_program();
        rv_pkg::retire_t exp_r;
        cycle_limit += 40 * expq.size();
        @(posedge clk);
        rst <= 1'b0;
        while (expq.size() > 0) begin
            exp_r = expq.pop_front();
            @(negedge clk);
            while (!retire_valid) begin
                @(negedge clk);
            end
            check("retire.pc", exp_r.pc, retire.pc);
            check("retire.we", 32'(exp_r.we), 32'(retire.we));
            if (exp_r.we) begin
                check("retire.rd", 32'(exp_r.rd), 32'(retire.rd));
                check("retire.wdata", exp_r.wdata, retire.wdata);
            end
        end
    endtask

    task automatic alu_ops(logic stall);
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        a = 32'd100;
        b = 32'hffff_fff9;
        start_reset(stall);
        emit(i_type(OP_IMM, 3'b000, 1, 0, 100), 1, a);
        emit(i_type(OP_IMM, 3'b000, 2, 0, -7), 2, b);
        emit(r_type(7'h00, 3'b000, 3, 1, 2), 3, a + b);
        emit(r_type(7'h20, 3'b000, 4, 2, 1), 4, b - a);
        emit(r_type(7'h00, 3'b111, 5, 1, 2), 5, a & b);
        emit(r_type(7'h00, 3'b110, 6, 1, 2), 6, a | b);
        emit(r_type(7'h00, 3'b100, 7, 1, 2), 7, a ^ b);
        emit(r_type(7'h00, 3'b001, 8, 2, 1), 8, b << 4); // Shift by 100 mod 32.
        emit(r_type(7'h00, 3'b101, 9, 2, 1), 9, b >> 4);
        emit(r_type(7'h20, 3'b101, 10, 2, 1), 10, 32'hffff_ffff);
        emit(r_type(7'h00, 3'b010, 11, 2, 1), 11, 32'd1);
        emit(r_type(7'h00, 3'b010, 12, 1, 2), 12, 32'd0);
        emit(r_type(7'h00, 3'b011, 13, 2, 1), 13, 32'd0);
        emit(r_type(7'h00, 3'b011, 14, 1, 2), 14, 32'd1);
        emit(i_type(OP_IMM, 3'b001, 15, 1, 3), 15, a << 3);
        emit(i_type(OP_IMM, 3'b101, 16, 2, 28), 16, 32'h0000_000f);
        emit(i_type(OP_IMM, 3'b101, 17, 2, 12'h401), 17, 32'hffff_fffc);
        emit(i_type(OP_IMM, 3'b111, 18, 2, 12'h0f0), 18, b & 32'h0000_00f0);
        emit(i_type(OP_IMM, 3'b110, 19, 1, -256), 19, a | 32'hffff_ff00);
        emit(i_type(OP_IMM, 3'b100, 20, 2, -1), 20, ~b);
        emit(i_type(OP_IMM, 3'b010, 21, 2, -6), 21, 32'd1);
        emit(i_type(OP_IMM, 3'b011, 22, 1, -1), 22, 32'd1);
        emit(i_type(OP_IMM, 3'b000, 0, 1, 5), 0, 0);
        emit(r_type(7'h00, 3'b000, 23, 0, 0), 23, 32'd0);
        emit(32'hffff_ffff, 0, 0); // Unknown opcode.
        halt();
        run_program();
    endtask

    task automatic upper_imms(logic stall);
        start_reset(stall);
        emit(u_type(OP_LUI, 1, 20'h12345), 1, 32'h1234_5000);
        emit(u_type(OP_LUI, 2, 20'hfffff), 2, 32'hffff_f000);
        emit(u_type(OP_AUIPC, 3, 20'h00001), 3, pc_build + 32'h0000_1000);
        emit(u_type(OP_AUIPC, 4, 20'h80000), 4, pc_build + 32'h8000_0000);
        emit(u_type(OP_AUIPC, 0, 20'h00005), 0, 0);
        halt();
        run_program();
    endtask

    task automatic loads_stores(logic stall);
        start_reset(stall);
        place(32'h100, 32'h80f1_7f82);
        place(32'h104, 32'haaaa_aaaa);
        place(32'h108, 32'haaaa_aaaa);
        place(32'h10c, 32'haaaa_aaaa);
        emit(i_type(OP_IMM, 3'b000, 1, 0, 12'h100), 1, 32'h0000_0100);
        emit(i_type(OP_LOAD, 3'b010, 2, 1, 0), 2, 32'h80f1_7f82);
        emit(i_type(OP_LOAD, 3'b000, 3, 1, 0), 3, 32'hffff_ff82);
        emit(i_type(OP_LOAD, 3'b100, 4, 1, 0), 4, 32'h0000_0082);
        emit(i_type(OP_LOAD, 3'b000, 5, 1, 1), 5, 32'h0000_007f);
        emit(i_type(OP_LOAD, 3'b000, 6, 1, 2), 6, 32'hffff_fff1);
        emit(i_type(OP_LOAD, 3'b100, 7, 1, 3), 7, 32'h0000_0080);
        emit(i_type(OP_LOAD, 3'b001, 8, 1, 0), 8, 32'h0000_7f82);
        emit(i_type(OP_LOAD, 3'b001, 9, 1, 2), 9, 32'hffff_80f1);
        emit(i_type(OP_LOAD, 3'b101, 10, 1, 2), 10, 32'h0000_80f1);
        emit(u_type(OP_LUI, 11, 20'h12345), 11, 32'h1234_5000);
        emit(i_type(OP_IMM, 3'b000, 11, 11, 12'h678), 11, 32'h1234_5678);
        emit(s_type(3'b000, 1, 11, 5), 0, 0);
        emit(s_type(3'b000, 1, 11, 7), 0, 0);
        emit(s_type(3'b001, 1, 11, 10), 0, 0);
        emit(s_type(3'b010, 1, 11, 12), 0, 0);
        emit(s_type(3'b001, 1, 11, 8), 0, 0);
        emit(i_type(OP_LOAD, 3'b010, 12, 1, 4), 12, 32'h78aa_78aa);
        emit(i_type(OP_LOAD, 3'b101, 13, 1, 10), 13, 32'h0000_5678);
        emit(i_type(OP_LOAD, 3'b000, 14, 1, 7), 14, 32'h0000_0078);
        emit(i_type(OP_LOAD, 3'b010, 15, 1, -4), 15, fill_word(32'h0fc));
        halt();
        run_program();
        check("mem[0x100]", 32'h80f1_7f82, word_at(32'h100));
        check("mem[0x104]", 32'h78aa_78aa, word_at(32'h104));
        check("mem[0x108]", 32'h5678_5678, word_at(32'h108));
        check("mem[0x10c]", 32'h1234_5678, word_at(32'h10c));
        check("mem[0x110]", fill_word(32'h110), word_at(32'h110));
    endtask

    task automatic branches_jumps(logic stall);
        rv_pkg::word_t p;
        start_reset(stall);
        emit(i_type(OP_IMM, 3'b000, 1, 0, 5), 1, 32'd5);
        emit(i_type(OP_IMM, 3'b000, 2, 0, -3), 2, 32'hffff_fffd);
        emit(i_type(OP_IMM, 3'b000, 3, 0, 5), 3, 32'd5);
        branch(3'b000, 1, 3, 1'b1);
        branch(3'b000, 1, 2, 1'b0);
        branch(3'b001, 1, 2, 1'b1);
        branch(3'b001, 1, 3, 1'b0);
        branch(3'b100, 2, 1, 1'b1);
        branch(3'b100, 1, 2, 1'b0);
        branch(3'b101, 1, 2, 1'b1);
        branch(3'b101, 1, 3, 1'b1); // Equal operands.
        branch(3'b101, 2, 1, 1'b0);
        branch(3'b110, 1, 2, 1'b1);
        branch(3'b110, 2, 1, 1'b0);
        branch(3'b111, 2, 1, 1'b1);
        branch(3'b111, 1, 2, 1'b0);
        // Forward jal, then a backward branch into the skipped slot.
        p = pc_build;
        place(p, j_type(4, 12));
        place(p + 4, i_type(OP_IMM, 3'b000, 5, 0, 77));
        place(p + 8, j_type(0, 8));
        place(p + 12, b_type(3'b100, 2, 1, -8));
        expect_retire(p, 4, p + 4);
        expect_retire(p + 12, 0, 0);
        expect_retire(p + 4, 5, 32'd77);
        expect_retire(p + 8, 0, 0);
        pc_build = p + 16;
        emit(u_type(OP_AUIPC, 7, 20'h00000), 7, pc_build);
        emit(i_type(OP_JALR, 3'b000, 8, 7, 13), 8, pc_build + 4); // Odd target.
        skip_slot();
        halt();
        run_program();
    endtask

    initial begin
        int round;
        rst      = 1'b1;
        stall_en = 1'b0;
        for (round = 0; round < 2; round++) begin
            alu_ops(round == 1);
            upper_imms(round == 1);
            loads_stores(round == 1);
            branches_jumps(round == 1);
        end
        if (fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall_en,
    input  wire                   imem_req_valid,
    input  wire rv_pkg::mem_req_t imem_req,
    output logic                  imem_req_ready,
    output logic                  imem_resp_valid,
    output rv_pkg::word_t         imem_resp_rdata,
    input  wire                   dmem_req_valid,
    input  wire rv_pkg::mem_req_t dmem_req,
    output logic                  dmem_req_ready,
    output logic                  dmem_resp_valid,
    output rv_pkg::word_t         dmem_resp_rdata
);

    // 4 KiB of code and data indexed by addr[11:2].
    rv_pkg::word_t mem [0:1023];
    integer        seed;
    integer        lane;
    logic [31:0]   draw;
    logic          i_pend;
    logic          d_pend;
    logic [1:0]    i_wait;
    logic [1:0]    d_wait;
    rv_pkg::word_t i_data;
    rv_pkg::word_t d_data;

    initial begin
        seed            = 87581;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_rdata = '0;
        dmem_req_ready  = 1'b0;
        dmem_resp_valid = 1'b0;
        dmem_resp_rdata = '0;
    end

    always @(posedge clk) begin
        draw = $random(seed); // One draw per cycle feeds both ports.
        if (rst) begin
            imem_req_ready  <= 1'b0;
            imem_resp_valid <= 1'b0;
            dmem_req_ready  <= 1'b0;
            dmem_resp_valid <= 1'b0;
            i_pend          <= 1'b0;
            d_pend          <= 1'b0;
        end else begin
            imem_resp_valid <= 1'b0;
            dmem_resp_valid <= 1'b0;
            imem_req_ready  <= stall_en ? draw[0] : 1'b1;
            dmem_req_ready  <= stall_en ? draw[1] : 1'b1;

            if (imem_req_valid && imem_req_ready) begin
                i_pend <= 1'b1;
                i_wait <= stall_en ? draw[3:2] : 2'd0;
                i_data <= mem[imem_req.addr[11:2]];
            end else if (i_pend) begin
                if (i_wait == 2'd0) begin
                    imem_resp_valid <= 1'b1;
                    imem_resp_rdata <= i_data;
                    i_pend          <= 1'b0;
                end else begin
                    i_wait <= i_wait - 2'd1;
                end
            end

            if (dmem_req_valid && dmem_req_ready) begin
                d_pend <= 1'b1;
                d_wait <= stall_en ? draw[5:4] : 2'd0;
                d_data <= mem[dmem_req.addr[11:2]];
                if (dmem_req.we) begin
                    for (lane = 0; lane < 4; lane = lane + 1) begin
                        if (dmem_req.strb[lane]) begin
                            mem[dmem_req.addr[11:2]][lane*8 +: 8] <= dmem_req.wdata[lane*8 +: 8];
                        end
                    end
                end
            end else if (d_pend) begin
                if (d_wait == 2'd0) begin
                    dmem_resp_valid <= 1'b1;
                    dmem_resp_rdata <= d_data; // Ignored by the core for stores.
                    d_pend          <= 1'b0;
                end else begin
                    d_wait <= d_wait - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: flist.f
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_pc.sv
logic/rv_control.sv
logic/rv_core.sv
bench/tb_mem.sv
bench/rv_core_tb.sv

// File: logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire rv_pkg::alu_op_t op,
    input  wire rv_pkg::word_t   a,
    input  wire rv_pkg::word_t   b,
    output rv_pkg::word_t        result,
    output logic                 eq,
    output logic                 lt,
    output logic                 ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Branches read the compares directly.
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_slt:  result = {31'b0, lt};
            rv_pkg::alu_sltu: result = {31'b0, ltu};
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $signed(a) >>> shamt;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_and:  result = a & b;
            default:          result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_control.sv
`timescale 1ns/1ps
`default_nettype none

module rv_control (
    input  wire                   clk,
    input  wire                   rst,
    output logic                  imem_req_valid,
    output rv_pkg::mem_req_t      imem_req,
    input  wire                   imem_req_ready,
    input  wire                   imem_resp_valid,
    input  wire rv_pkg::word_t    imem_resp_rdata,
    output logic                  dmem_req_valid,
    output rv_pkg::mem_req_t      dmem_req,
    input  wire                   dmem_req_ready,
    input  wire                   dmem_resp_valid,
    input  wire rv_pkg::word_t    dmem_resp_rdata,
    input  wire rv_pkg::decoded_t dec,
    output rv_pkg::word_t         instr,
    output logic                  rf_we,
    output rv_pkg::word_t         rf_wdata,
    input  wire rv_pkg::word_t    rs1_data,
    input  wire rv_pkg::word_t    rs2_data,
    output rv_pkg::alu_op_t       alu_op,
    output rv_pkg::word_t         alu_a,
    output rv_pkg::word_t         alu_b,
    input  wire rv_pkg::word_t    alu_result,
    input  wire                   eq,
    input  wire                   lt,
    input  wire                   ltu,
    input  wire rv_pkg::word_t    pc,
    input  wire rv_pkg::word_t    pc_plus4,
    output rv_pkg::pc_sel_t       pc_sel,
    output logic                  retire_valid,
    output rv_pkg::retire_t       retire
);

    rv_pkg::core_state_t state;
    rv_pkg::word_t       rs1_q;
    rv_pkg::word_t       rs2_q;
    rv_pkg::word_t       alu_q;
    rv_pkg::word_t       load_q;
    logic                taken_q;
    logic                taken;
    logic                use_pc_a;
    logic                use_imm_b;
    logic                is_mem;
    logic                has_rd;
    logic                wb_we;

    function automatic logic [3:0] store_strb(rv_pkg::mem_width_t w, logic [1:0] offs);
        case (w)
            rv_pkg::mem_byte: return 4'b0001 << offs;
            rv_pkg::mem_half: return 4'b0011 << {offs[1], 1'b0};
            default:          return 4'b1111;
        endcase
    endfunction

    function automatic rv_pkg::word_t load_align(rv_pkg::word_t raw, logic [1:0] offs,
                                                 rv_pkg::mem_width_t w, logic uns);
        rv_pkg::word_t sh;
        sh = raw >> {offs, 3'b000};
        case (w)
            rv_pkg::mem_byte: return uns ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            rv_pkg::mem_half: return uns ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default:          return sh;
        endcase
    endfunction

    assign use_pc_a  = (dec.op_class == rv_pkg::op_auipc) || (dec.op_class == rv_pkg::op_jal);
    assign use_imm_b = (dec.op_class != rv_pkg::op_alu_reg) &&
                       (dec.op_class != rv_pkg::op_branch);
    assign is_mem    = (dec.op_class == rv_pkg::op_load) || (dec.op_class == rv_pkg::op_store);

    // Operands come from registers, so the ALU output holds through writeback.
    assign alu_op = dec.alu_op;
    assign alu_a  = use_pc_a ? pc : rs1_q;
    assign alu_b  = use_imm_b ? dec.imm : rs2_q;

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = eq;
            3'b001:  taken = !eq;
            3'b100:  taken = lt;
            3'b101:  taken = !lt;
            3'b110:  taken = ltu;
            3'b111:  taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.op_class)
            rv_pkg::op_alu_reg, rv_pkg::op_alu_imm, rv_pkg::op_lui, rv_pkg::op_auipc,
            rv_pkg::op_jal, rv_pkg::op_jalr, rv_pkg::op_load: has_rd = 1'b1;
            default: has_rd = 1'b0;
        endcase
    end

    assign wb_we = has_rd && (dec.rd != '0);

    always_comb begin
        case (dec.op_class)
            rv_pkg::op_lui:                 rf_wdata = dec.imm;
            rv_pkg::op_jal, rv_pkg::op_jalr: rf_wdata = pc_plus4;
            rv_pkg::op_load:                rf_wdata = load_q;
            default:                        rf_wdata = alu_q;
        endcase
    end

    always_comb begin
        pc_sel = rv_pkg::pc_hold;
        if (state == rv_pkg::st_writeback) begin
            case (dec.op_class)
                rv_pkg::op_jal:    pc_sel = rv_pkg::pc_rel;
                rv_pkg::op_jalr:   pc_sel = rv_pkg::pc_abs;
                rv_pkg::op_branch: pc_sel = taken_q ? rv_pkg::pc_rel : rv_pkg::pc_seq;
                default:           pc_sel = rv_pkg::pc_seq;
            endcase
        end
    end

    assign imem_req     = '{addr: pc, wdata: '0, strb: 4'b1111, we: 1'b0};
    assign rf_we        = (state == rv_pkg::st_writeback) && wb_we;
    assign retire_valid = (state == rv_pkg::st_writeback);
    assign retire       = '{pc: pc, rd: dec.rd, wdata: rf_wdata, we: wb_we};

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= rv_pkg::st_fetch;
            imem_req_valid <= 1'b0;
            dmem_req_valid <= 1'b0;
        end else begin
            case (state)
                rv_pkg::st_fetch: begin
                    if (imem_req_valid && imem_req_ready) begin
                        imem_req_valid <= 1'b0;
                        state          <= rv_pkg::st_fetch_wait;
                    end else begin
                        imem_req_valid <= 1'b1; // First fetch after reset.
                    end
                end
                rv_pkg::st_fetch_wait: begin
                    if (imem_resp_valid) state <= rv_pkg::st_decode;
                end
                rv_pkg::st_decode: state <= rv_pkg::st_execute;
                rv_pkg::st_execute: begin
                    if (is_mem) begin
                        dmem_req_valid <= 1'b1;
                        state          <= rv_pkg::st_mem;
                    end else begin
                        state <= rv_pkg::st_writeback;
                    end
                end
                rv_pkg::st_mem: begin
                    if (dmem_req_ready) begin
                        dmem_req_valid <= 1'b0;
                        state          <= rv_pkg::st_mem_wait;
                    end
                end
                rv_pkg::st_mem_wait: begin
                    if (dmem_resp_valid) state <= rv_pkg::st_writeback;
                end
                rv_pkg::st_writeback: begin
                    imem_req_valid <= 1'b1; // Next fetch issues at once.
                    state          <= rv_pkg::st_fetch;
                end
                default: state <= rv_pkg::st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_pkg::st_fetch_wait && imem_resp_valid) begin
            instr <= imem_resp_rdata;
        end
        if (state == rv_pkg::st_decode) begin
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
        if (state == rv_pkg::st_execute) begin
            alu_q   <= alu_result;
            taken_q <= taken;
            if (is_mem) begin
                dmem_req.addr  <= alu_result;
                dmem_req.wdata <= rs2_q << {alu_result[1:0], 3'b000}; // Lane shift.
                dmem_req.strb  <= store_strb(dec.width, alu_result[1:0]);
                dmem_req.we    <= (dec.op_class == rv_pkg::op_store);
            end
        end
        if (state == rv_pkg::st_mem_wait && dmem_resp_valid) begin
            load_q <= load_align(dmem_resp_rdata, dmem_req.addr[1:0], dec.width, dec.funct3[2]);
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                clk,
    input  wire                rst,
    output logic               imem_req_valid,
    output rv_pkg::mem_req_t   imem_req,
    input  wire                imem_req_ready,
    input  wire                imem_resp_valid,
    input  wire rv_pkg::word_t imem_resp_rdata,
    output logic               dmem_req_valid,
    output rv_pkg::mem_req_t   dmem_req,
    input  wire                dmem_req_ready,
    input  wire                dmem_resp_valid,
    input  wire rv_pkg::word_t dmem_resp_rdata,
    output logic               retire_valid,
    output rv_pkg::retire_t    retire
);

    rv_pkg::decoded_t dec;
    rv_pkg::word_t    instr;
    logic             rf_we;
    rv_pkg::word_t    rf_wdata;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    rv_pkg::alu_op_t  alu_op;
    rv_pkg::word_t    alu_a;
    rv_pkg::word_t    alu_b;
    rv_pkg::word_t    alu_result;
    logic             eq;
    logic             lt;
    logic             ltu;
    rv_pkg::word_t    pc;
    rv_pkg::word_t    pc_plus4;
    rv_pkg::pc_sel_t  pc_sel;

    rv_control control_i (
        .clk, .rst,
        .imem_req_valid, .imem_req, .imem_req_ready, .imem_resp_valid, .imem_resp_rdata,
        .dmem_req_valid, .dmem_req, .dmem_req_ready, .dmem_resp_valid, .dmem_resp_rdata,
        .dec, .instr, .rf_we, .rf_wdata, .rs1_data, .rs2_data,
        .alu_op, .alu_a, .alu_b, .alu_result, .eq, .lt, .ltu,
        .pc, .pc_plus4, .pc_sel, .retire_valid, .retire
    );

    rv_decoder decoder_i (.instr, .dec);

    rv_regfile regfile_i (
        .clk,
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr0 (dec.rs1),
        .raddr1 (dec.rs2),
        .rdata0 (rs1_data),
        .rdata1 (rs2_data)
    );

    rv_alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .eq, .lt, .ltu);

    // The ALU output in writeback still holds the JALR target rs1 + imm.
    rv_pc pc_i (
        .clk, .rst,
        .sel    (pc_sel),
        .imm    (dec.imm),
        .target (alu_result),
        .pc,
        .pc_plus4
    );

endmodule

`default_nettype wire

// File: logic/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire rv_pkg::word_t     instr,
    output rv_pkg::decoded_t       dec
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic          funct7_b5;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        dec.funct3   = funct3;
        dec.alu_op   = rv_pkg::alu_add;
        dec.op_class = rv_pkg::op_illegal;
        case (funct3[1:0])
            2'b00:   dec.width = rv_pkg::mem_byte;
            2'b01:   dec.width = rv_pkg::mem_half;
            default: dec.width = rv_pkg::mem_word;
        endcase

        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                dec.op_class = (opcode == rv_pkg::OPC_OP) ? rv_pkg::op_alu_reg
                                                          : rv_pkg::op_alu_imm;
                dec.imm      = imm_i;
                case (funct3)
                    3'b000: dec.alu_op = (opcode == rv_pkg::OPC_OP && funct7_b5) ?
                                         rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b001: dec.alu_op = rv_pkg::alu_sll;
                    3'b010: dec.alu_op = rv_pkg::alu_slt;
                    3'b011: dec.alu_op = rv_pkg::alu_sltu;
                    3'b100: dec.alu_op = rv_pkg::alu_xor;
                    3'b101: dec.alu_op = funct7_b5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110: dec.alu_op = rv_pkg::alu_or;
                    default: dec.alu_op = rv_pkg::alu_and;
                endcase
            end
            rv_pkg::OPC_LUI:   begin dec.op_class = rv_pkg::op_lui;   dec.imm = imm_u; end
            rv_pkg::OPC_AUIPC: begin dec.op_class = rv_pkg::op_auipc; dec.imm = imm_u; end
            rv_pkg::OPC_JAL:   begin dec.op_class = rv_pkg::op_jal;   dec.imm = imm_j; end
            rv_pkg::OPC_JALR:  begin dec.op_class = rv_pkg::op_jalr;  dec.imm = imm_i; end
            rv_pkg::OPC_LOAD:  begin dec.op_class = rv_pkg::op_load;  dec.imm = imm_i; end
            rv_pkg::OPC_STORE: begin dec.op_class = rv_pkg::op_store; dec.imm = imm_s; end
            rv_pkg::OPC_BRANCH: begin
                dec.op_class = rv_pkg::op_branch;
                dec.imm      = imm_b;
                case (funct3[2:1])
                    2'b10:   dec.alu_op = rv_pkg::alu_slt; // blt, bge.
                    2'b11:   dec.alu_op = rv_pkg::alu_sltu;
                    default: dec.alu_op = rv_pkg::alu_sub;
                endcase
            end
            default: dec.op_class = rv_pkg::op_illegal; // Retires as a no-op.
        endcase
    end

endmodule

`default_nettype wire

// File: logic/rv_pc.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pc (
    input  wire                  clk,
    input  wire                  rst,
    input  wire rv_pkg::pc_sel_t sel,
    input  wire rv_pkg::word_t   imm,
    input  wire rv_pkg::word_t   target,
    output rv_pkg::word_t        pc,
    output rv_pkg::word_t        pc_plus4
);

    rv_pkg::word_t pc_next;

    assign pc_plus4 = pc + 32'd4; // Link value.

    always_comb begin
        case (sel)
            rv_pkg::pc_seq: pc_next = pc_plus4;
            rv_pkg::pc_rel: pc_next = pc + imm;
            rv_pkg::pc_abs: pc_next = {target[31:1], 1'b0};
            default:        pc_next = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= rv_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0800;
    localparam int    NUM_REGS = 32;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        op_alu_reg,
        op_alu_imm,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_illegal
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // Encoded like funct3[1:0].
    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_width_t;

    typedef enum logic [1:0] {
        pc_hold,
        pc_seq,
        pc_rel,
        pc_abs
    } pc_sel_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_mem,
        st_mem_wait,
        st_writeback
    } core_state_t;

    typedef struct packed {
        op_class_t  op_class;
        alu_op_t    alu_op;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        word_t      imm;
        logic [2:0] funct3;
        mem_width_t width;
    } decoded_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] strb;
        logic       we;
    } mem_req_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     wdata;
        logic      we;
    } retire_t;

endpackage

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                    clk,
    input  wire                    we,
    input  wire rv_pkg::reg_addr_t waddr,
    input  wire rv_pkg::word_t     wdata,
    input  wire rv_pkg::reg_addr_t raddr0,
    input  wire rv_pkg::reg_addr_t raddr1,
    output rv_pkg::word_t          rdata0,
    output rv_pkg::word_t          rdata1
);

    // No storage for x0.
    rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire
